// File: common/sifh_pkg.sv
`default_nettype none

package sifh_pkg;

    // Default sizes, overridden from the top level
    localparam int DEF_NP      = 8;
    localparam int DEF_NB      = 4;     // 16 bins per pixel
    localparam int DEF_PIXELS  = 4;
    localparam int DEF_ACQ_NUM = 16;

    // Histogram count width, enough for ACQ_NUM up to 65535
    localparam int CNT_W = 16;

    typedef enum logic [1:0] {
        SRCH_IDLE,
        SRCH_READ,
        SRCH_LAST,
        SRCH_EMIT
    } search_state_t;

    // Four-phase link states
    typedef enum logic [1:0] {
        LNK_IDLE,
        LNK_ACK,
        LNK_RELEASE
    } link_state_t;

endpackage

`default_nettype wire

// File: hdl/result_out.sv
`default_nettype none
`timescale 1ns/1ps

module result_out #(
    parameter int  NB     = sifh_pkg::DEF_NB,
    parameter int  PIXELS = sifh_pkg::DEF_PIXELS,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       pk_valid,
    input  logic [PIX_W-1:0]           pk_pixel,
    input  logic [NB-1:0]              pk_bin,
    input  logic [sifh_pkg::CNT_W-1:0] pk_count,
    output logic                       pk_ready,
    output logic                       out_req,
    input  logic                       out_ack,
    output logic [PIX_W-1:0]           out_pixel,
    output logic [NB-1:0]              out_bin,
    output logic [sifh_pkg::CNT_W-1:0] out_count
);

    sifh_pkg::link_state_t state;

    assign pk_ready = (state == sifh_pkg::LNK_IDLE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= sifh_pkg::LNK_IDLE;
            out_req <= 1'b0;
        end else begin
            case (state)
                sifh_pkg::LNK_IDLE: begin
                    if (pk_valid) begin
                        out_req <= 1'b1;
                        state   <= sifh_pkg::LNK_ACK;
                    end
                end
                sifh_pkg::LNK_ACK: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= sifh_pkg::LNK_RELEASE;
                    end
                end
                sifh_pkg::LNK_RELEASE: begin
                    if (!out_ack) state <= sifh_pkg::LNK_IDLE;   // Sink done
                end
                default: state <= sifh_pkg::LNK_IDLE;
            endcase
        end
    end

    // Held for the whole link cycle
    always_ff @(posedge clk) begin
        if (pk_valid && pk_ready) begin
            out_pixel <= pk_pixel;
            out_bin   <= pk_bin;
            out_count <= pk_count;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sample_in.sv
`default_nettype none
`timescale 1ns/1ps

module sample_in #(
    parameter int  NP      = sifh_pkg::DEF_NP,
    parameter int  NB      = sifh_pkg::DEF_NB,
    parameter int  PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int  ACQ_NUM = sifh_pkg::DEF_ACQ_NUM,
    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic             clk,
    input  logic             res,
    input  logic             in_req,
    input  logic [NP-1:0]    in_data,
    output logic             in_ack,
    input  logic             search_busy,
    output logic             acc_valid,
    output logic [PIX_W-1:0] acc_pixel,
    output logic [NB-1:0]    acc_bin,
    output logic             frame_done
);

    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;
    localparam int WU_W  = NB + PIX_W;

    sifh_pkg::link_state_t state;

    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic [WU_W:0]    wu_cnt;   // Same length as the RAM clear sweep
    logic             lock;
    logic             busy_q;
    logic             accept;
    logic             take;
    logic             last_sample;

    assign accept      = wu_cnt[WU_W] && !lock;
    assign take        = (state == sifh_pkg::LNK_IDLE) && in_req && accept;
    assign last_sample = (pix_cnt == PIX_W'(PIXELS - 1)) &&
                         (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= sifh_pkg::LNK_IDLE;
            in_ack     <= 1'b0;
            acc_valid  <= 1'b0;
            frame_done <= 1'b0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
            wu_cnt     <= '0;
            lock       <= 1'b0;
            busy_q     <= 1'b0;
        end else begin
            acc_valid  <= 1'b0;
            frame_done <= 1'b0;
            busy_q     <= search_busy;
            if (!wu_cnt[WU_W]) begin
                wu_cnt <= wu_cnt + 1'b1;
            end
            if (busy_q && !search_busy) begin
                lock <= 1'b0;   // Last result taken
            end
            case (state)
                sifh_pkg::LNK_IDLE: begin
                    if (take) begin
                        in_ack    <= 1'b1;
                        acc_valid <= 1'b1;
                        state     <= sifh_pkg::LNK_ACK;
                        if (pix_cnt == PIX_W'(PIXELS - 1)) begin
                            pix_cnt <= '0;
                            acq_cnt <= last_sample ? '0 : acq_cnt + 1'b1;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                        if (last_sample) begin
                            frame_done <= 1'b1;
                            lock       <= 1'b1;
                        end
                    end
                end
                sifh_pkg::LNK_ACK: begin
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= sifh_pkg::LNK_RELEASE;
                    end
                end
                default: state <= sifh_pkg::LNK_IDLE;   // One turnaround cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_pixel <= pix_cnt;
            acc_bin   <= in_data[NP-1 -: NB];   // Upper bits pick the bin
        end
    end

endmodule

`default_nettype wire

// File: hdl/sifh_top.sv
`default_nettype none
`timescale 1ns/1ps

module sifh_top #(
    parameter int  NP      = sifh_pkg::DEF_NP,
    parameter int  NB      = sifh_pkg::DEF_NB,
    parameter int  PIXELS  = sifh_pkg::DEF_PIXELS,
    parameter int  ACQ_NUM = sifh_pkg::DEF_ACQ_NUM,
    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       in_req,
    input  logic [NP-1:0]              in_data,
    output logic                       in_ack,
    output logic                       out_req,
    input  logic                       out_ack,
    output logic [PIX_W-1:0]           out_pixel,
    output logic [NB-1:0]              out_bin,
    output logic [sifh_pkg::CNT_W-1:0] out_count
);

    logic                       acc_valid;
    logic [PIX_W-1:0]           acc_pixel;
    logic [NB-1:0]              acc_bin;
    logic                       frame_done;
    logic                       search_busy;
    logic                       rd_en;
    logic [PIX_W-1:0]           rd_pixel;
    logic [NB-1:0]              rd_bin;
    logic [sifh_pkg::CNT_W-1:0] rd_count;
    logic                       pk_ready;
    logic                       pk_valid;
    logic [PIX_W-1:0]           pk_pixel;
    logic [NB-1:0]              pk_bin;
    logic [sifh_pkg::CNT_W-1:0] pk_count;

    sample_in #(.NP(NP), .NB(NB), .PIXELS(PIXELS), .ACQ_NUM(ACQ_NUM)) u_sample_in (
        .clk         (clk),
        .res         (res),
        .in_req      (in_req),
        .in_data     (in_data),
        .in_ack      (in_ack),
        .search_busy (search_busy),
        .acc_valid   (acc_valid),
        .acc_pixel   (acc_pixel),
        .acc_bin     (acc_bin),
        .frame_done  (frame_done)
    );

    hist_accum #(.NB(NB), .PIXELS(PIXELS)) u_hist_accum (
        .clk       (clk),
        .res       (res),
        .acc_valid (acc_valid),
        .acc_pixel (acc_pixel),
        .acc_bin   (acc_bin),
        .rd_en     (rd_en),
        .rd_pixel  (rd_pixel),
        .rd_bin    (rd_bin),
        .rd_count  (rd_count)
    );

    peak_search #(.NB(NB), .PIXELS(PIXELS)) u_peak_search (
        .clk         (clk),
        .res         (res),
        .frame_done  (frame_done),
        .search_busy (search_busy),
        .rd_en       (rd_en),
        .rd_pixel    (rd_pixel),
        .rd_bin      (rd_bin),
        .rd_count    (rd_count),
        .pk_ready    (pk_ready),
        .pk_valid    (pk_valid),
        .pk_pixel    (pk_pixel),
        .pk_bin      (pk_bin),
        .pk_count    (pk_count)
    );

    result_out #(.NB(NB), .PIXELS(PIXELS)) u_result_out (
        .clk       (clk),
        .res       (res),
        .pk_valid  (pk_valid),
        .pk_pixel  (pk_pixel),
        .pk_bin    (pk_bin),
        .pk_count  (pk_count),
        .pk_ready  (pk_ready),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count)
    );

endmodule

`default_nettype wire

// File: histogram/hist_accum.sv
`default_nettype none
`timescale 1ns/1ps

module hist_accum #(
    parameter int  NB     = sifh_pkg::DEF_NB,
    parameter int  PIXELS = sifh_pkg::DEF_PIXELS,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       acc_valid,
    input  logic [PIX_W-1:0]           acc_pixel,
    input  logic [NB-1:0]              acc_bin,
    input  logic                       rd_en,
    input  logic [PIX_W-1:0]           rd_pixel,
    input  logic [NB-1:0]              rd_bin,
    output logic [sifh_pkg::CNT_W-1:0] rd_count
);

    localparam int ADDR_W = PIX_W + NB;
    localparam int DEPTH  = 2 ** ADDR_W;

    logic [sifh_pkg::CNT_W-1:0] mem [DEPTH];

    logic [ADDR_W:0]            sw_cnt;
    logic                       sweeping;
    logic                       inc_pend;
    logic [ADDR_W-1:0]          inc_addr;
    logic [ADDR_W-1:0]          acc_addr;
    logic [ADDR_W-1:0]          rd_addr;
    logic [sifh_pkg::CNT_W-1:0] inc_data;
    logic [sifh_pkg::CNT_W-1:0] inc_sum;

    assign sweeping = !sw_cnt[ADDR_W];
    assign acc_addr = {acc_pixel, acc_bin};
    assign rd_addr  = {rd_pixel, rd_bin};
    assign inc_sum  = inc_data + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sw_cnt   <= '0;
            inc_pend <= 1'b0;
        end else begin
            if (sweeping) begin
                sw_cnt <= sw_cnt + 1'b1;
            end
            inc_pend <= acc_valid && !sweeping;
        end
    end

    always_ff @(posedge clk) begin
        // Read stage of the increment
        if (acc_valid) begin
            inc_addr <= acc_addr;
            inc_data <= mem[acc_addr];
        end

        if (sweeping) begin
            mem[sw_cnt[ADDR_W-1:0]] <= '0;
        end else begin
            if (inc_pend) begin
                mem[inc_addr] <= inc_sum;   // Write stage
            end
            // Clear after read, wins over a late increment to the same bin
            if (rd_en) begin
                mem[rd_addr] <= '0;
            end
        end

        if (rd_en) begin
            if (inc_pend && (inc_addr == rd_addr)) begin
                rd_count <= inc_sum;    // Increment still in flight
            end else begin
                rd_count <= mem[rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: histogram/peak_search.sv
`default_nettype none
`timescale 1ns/1ps

module peak_search #(
    parameter int  NB     = sifh_pkg::DEF_NB,
    parameter int  PIXELS = sifh_pkg::DEF_PIXELS,
    localparam int PIX_W  = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       frame_done,
    output logic                       search_busy,
    output logic                       rd_en,
    output logic [PIX_W-1:0]           rd_pixel,
    output logic [NB-1:0]              rd_bin,
    input  logic [sifh_pkg::CNT_W-1:0] rd_count,
    input  logic                       pk_ready,
    output logic                       pk_valid,
    output logic [PIX_W-1:0]           pk_pixel,
    output logic [NB-1:0]              pk_bin,
    output logic [sifh_pkg::CNT_W-1:0] pk_count
);

    sifh_pkg::search_state_t state;

    logic [PIX_W-1:0]           pix;
    logic [NB-1:0]              bin;
    logic [NB-1:0]              cmp_bin;    // Bin of the count now on rd_count
    logic                       cmp_valid;
    logic [NB-1:0]              best_bin;
    logic [sifh_pkg::CNT_W-1:0] best_cnt;

    assign rd_en    = (state == sifh_pkg::SRCH_READ);
    assign rd_pixel = pix;
    assign rd_bin   = bin;
    assign pk_valid = (state == sifh_pkg::SRCH_EMIT) && pk_ready;
    assign pk_pixel = pix;
    assign pk_bin   = best_bin;
    assign pk_count = best_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= sifh_pkg::SRCH_IDLE;
            search_busy <= 1'b0;
            pix         <= '0;
            bin         <= '0;
            cmp_valid   <= 1'b0;
        end else begin
            cmp_valid <= rd_en;
            case (state)
                sifh_pkg::SRCH_IDLE: begin
                    if (frame_done) begin
                        search_busy <= 1'b1;
                        pix         <= '0;
                        bin         <= '0;
                        state       <= sifh_pkg::SRCH_READ;
                    end
                end
                sifh_pkg::SRCH_READ: begin
                    bin <= bin + 1'b1;
                    if (bin == {NB{1'b1}}) begin
                        state <= sifh_pkg::SRCH_LAST;   // Last count still to come
                    end
                end
                sifh_pkg::SRCH_LAST: state <= sifh_pkg::SRCH_EMIT;
                sifh_pkg::SRCH_EMIT: begin
                    if (pk_ready) begin
                        if (pix == PIX_W'(PIXELS - 1)) begin
                            search_busy <= 1'b0;
                            state       <= sifh_pkg::SRCH_IDLE;
                        end else begin
                            pix   <= pix + 1'b1;
                            bin   <= '0;
                            state <= sifh_pkg::SRCH_READ;
                        end
                    end
                end
                default: state <= sifh_pkg::SRCH_IDLE;
            endcase
        end
    end

    // Strictly greater keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        cmp_bin <= bin;
        if (state == sifh_pkg::SRCH_IDLE || pk_valid) begin
            best_cnt <= '0;   // Held through EMIT until the result is taken
            best_bin <= '0;
        end
        if (cmp_valid && (rd_count > best_cnt)) begin
            best_cnt <= rd_count;
            best_bin <= cmp_bin;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f sifh_top.f --top-module sifh_tb -o sifh_sim

out=$(./obj_dir/sifh_sim)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: sifh_top.f
common/sifh_pkg.sv
hdl/sample_in.sv
histogram/hist_accum.sv
histogram/peak_search.sv
hdl/result_out.sv
hdl/sifh_top.sv
tb/sifh_tb.sv

// File: tb/sifh_tb.sv
`default_nettype none
`timescale 1ns/1ps

module sifh_tb;

    localparam int NP      = sifh_pkg::DEF_NP;
    localparam int NB      = sifh_pkg::DEF_NB;
    localparam int PIXELS  = sifh_pkg::DEF_PIXELS;
    localparam int ACQ_NUM = sifh_pkg::DEF_ACQ_NUM;
    localparam int PIX_W   = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int NBINS   = 2 ** NB;
    localparam int TIMEOUT = 2000;  // Cycles per wait

    logic                       clk;
    logic                       res;
    logic                       in_req;
    logic [NP-1:0]              in_data;
    logic                       in_ack;
    logic                       out_req;
    logic                       out_ack;
    logic [PIX_W-1:0]           out_pixel;
    logic [NB-1:0]              out_bin;
    logic [sifh_pkg::CNT_W-1:0] out_count;

    integer seed = 32'h6bef;
    int     errors;
    int     results_seen;
    int     seen_at_ack;    // Results started when the last in_ack rose
    int     carry;          // Samples of the next frame already sent
    int     hist [PIXELS][NBINS];
    int     exp_bin [PIXELS];
    int     exp_cnt [PIXELS];

    sifh_top #(.NP(NP), .NB(NB), .PIXELS(PIXELS), .ACQ_NUM(ACQ_NUM)) UUT (
        .clk       (clk),
        .res       (res),
        .in_req    (in_req),
        .in_data   (in_data),
        .in_ack    (in_ack),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pixel (out_pixel),
        .out_bin   (out_bin),
        .out_count (out_count)
    );

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
    endtask

    function automatic int rand_upto(input int max);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % (max + 1);
    endfunction

    // Sample k goes to pixel k mod PIXELS
    function automatic logic [NP-1:0] gen_sample(input int mode, input int k);
        int            p;
        int            a;
        logic [NP-1:0] data;
        p = k % PIXELS;
        a = k / PIXELS;
        case (mode)
            0: data = {NB'(a < 10 ? p * 5 + 3 : a + p), (NP - NB)'(k)};   // Dominant bin
            1: data = {NB'(a < 6 ? p + 9 : (a < 12 ? p + 2 : 0)), (NP - NB)'(k)};
            default: data = NP'($random(seed));
        endcase
        return data;
    endfunction

    function automatic void model_add(input int pixel, input logic [NP-1:0] data);
        hist[pixel][int'(data[NP-1 -: NB])]++;
    endfunction

    // Peak per pixel and empty histograms for the next frame
    function automatic void model_peaks();
        for (int p = 0; p < PIXELS; p++) begin
            exp_bin[p] = 0;
            exp_cnt[p] = 0;
            for (int b = 0; b < NBINS; b++) begin
                if (hist[p][b] > exp_cnt[p]) begin   // Ties keep the lower bin
                    exp_cnt[p] = hist[p][b];
                    exp_bin[p] = b;
                end
                hist[p][b] = 0;
            end
        end
    endfunction

    task automatic send_sample(input logic [NP-1:0] data);
        int n;
        @(negedge clk);
        in_data = data;
        in_req  = 1'b1;
        n = 0;
        while (!in_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!in_ack) timed_out("in_ack to rise");
        seen_at_ack = results_seen;
        in_req = 1'b0;
        n = 0;
        while (in_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (in_ack) timed_out("in_ack to fall");
    endtask

    task automatic check_held(input logic [PIX_W-1:0] pix, input logic [NB-1:0] bin,
                              input logic [sifh_pkg::CNT_W-1:0] cnt);
        if (out_req) begin
            check("out_pixel", 32'(out_pixel), 32'(pix));
            check("out_bin", 32'(out_bin), 32'(bin));
            check("out_count", 32'(out_count), 32'(cnt));
        end
    endtask

    task automatic recv_result(input int idx, input int ack_delay);
        int                         n;
        logic [PIX_W-1:0]           pix;
        logic [NB-1:0]              bin;
        logic [sifh_pkg::CNT_W-1:0] cnt;
        n = 0;
        while (!out_req && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!out_req) timed_out("out_req to rise");
        results_seen++;
        pix = out_pixel;
        bin = out_bin;
        cnt = out_count;
        check("out_pixel", 32'(pix), 32'(idx));
        check("out_bin", 32'(bin), 32'(exp_bin[idx]));
        check("out_count", 32'(cnt), 32'(exp_cnt[idx]));
        repeat (ack_delay) begin
            @(negedge clk);
            check_held(pix, bin, cnt);
        end
        out_ack = 1'b1;
        n = 0;
        while (out_req && n < TIMEOUT) begin
            check_held(pix, bin, cnt);
            @(negedge clk);
            n++;
        end
        if (out_req) timed_out("out_req to fall");
        out_ack = 1'b0;
    endtask

    task automatic run_frame(input int mode, input int ack_max, input bit offer_next);
        logic [NP-1:0] data;
        logic [NP-1:0] next_data;
        for (int k = carry; k < PIXELS * ACQ_NUM; k++) begin
            data = gen_sample(mode, k);
            model_add(k % PIXELS, data);
            send_sample(data);
        end
        model_peaks();
        results_seen = 0;
        carry        = 0;
        next_data    = NP'($random(seed));
        fork
            begin
                for (int p = 0; p < PIXELS; p++) begin
                    recv_result(p, (ack_max == 0) ? 0 : rand_upto(ack_max));
                end
            end
            begin
                if (offer_next) begin
                    // Offered during the search as sample 0 of the next frame
                    model_add(0, next_data);
                    send_sample(next_data);
                    check("results before in_ack", 32'(seen_at_ack), 32'(PIXELS));
                    carry = 1;
                end
            end
        join
        check("out_req", 32'(out_req), 32'(0));
    endtask

    initial begin
        clk     = 1'b0;
        res     = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
        check("in_ack", 32'(in_ack), 32'(0));
        check("out_req", 32'(out_req), 32'(0));
        run_frame(0, 0, 1'b0);
        run_frame(1, 0, 1'b0);      // Tie frame
        run_frame(2, 10, 1'b1);     // Slow sink
        run_frame(2, 30, 1'b0);     // Sink slower than a pixel scan
        finish_run();
    end

endmodule

`default_nettype wire
